/* Makefile */
# Verilator build and run of the k051960 frame control testbench
TOP = tb_k051960

.PHONY: all build run clean

all: run

build:
	verilator --binary --timescale 1ns/1ns --top-module $(TOP) -f k051960.f

# Fails unless the pass line shows up in the simulation output
run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "=== PASS ==="

clean:
	rm -rf obj_dir

/* k051960.f */
+incdir+rtl
rtl/k051960_pkg.sv
rtl/raster_counter.sv
rtl/cpu_regs.sv
rtl/irq_ctrl.sv
rtl/k051960.sv
tb/tb_k051960.sv

/* rtl/cpu_regs.sv */
// ==========================================================
// CPU register decode and storage, status read,
// ROM readback address and colour outputs
// ==========================================================
`include "k051960_config.svh"

module cpu_regs (
	input  logic                  clk_6M,
	input  logic                  RES_SYNC,
	input  k051960_pkg::cpu_bus_t bus,
	input  logic                  vblank,
	output k051960_pkg::ctrl_t    ctrl,
	output logic [7:0]            db_out,
	output logic [17:0]           ca,
	output logic [7:0]            oc
);
	import k051960_pkg::*;

	ctrl_t reg0;
	logic [7:0] reg2;
	logic [7:0] reg3;
	logic [1:0] reg4;
	logic reg_space;
	logic wr_cyc;
	logic rd_cyc;
	logic reg0_wr;
	logic reg2_wr;
	logic reg3_wr;
	logic reg4_wr;
	logic reg0_rd;

	// Registers live in the lowest 8 addresses
	assign reg_space = bus.cs && (bus.ab[10:3] == 8'h00);
	assign wr_cyc = reg_space && bus.wr;
	assign rd_cyc = reg_space && bus.rd;

	assign reg0_wr = wr_cyc && (bus.ab[2:0] == `K051960_REG0);
	assign reg2_wr = wr_cyc && (bus.ab[2:0] == `K051960_REG2);
	assign reg3_wr = wr_cyc && (bus.ab[2:0] == `K051960_REG3);
	assign reg4_wr = wr_cyc && (bus.ab[2:0] == `K051960_REG4);
	assign reg0_rd = rd_cyc && (bus.ab[2:0] == `K051960_REG0);

	// Register 0, interrupt enables and ROM readback mode
	always_ff @(posedge clk_6M or negedge RES_SYNC) begin
		if (!RES_SYNC) begin
			reg0 <= '0;
		end else if (reg0_wr) begin
			reg0.rom_read <= bus.db[`K051960_BIT_ROM_READ];
			reg0.irq_en <= bus.db[`K051960_BIT_IRQ_EN];
			reg0.firq_en <= bus.db[`K051960_BIT_FIRQ_EN];
			reg0.nmi_en <= bus.db[`K051960_BIT_NMI_EN];
		end
	end

	// ROM bank and colour registers
	always_ff @(posedge clk_6M) begin
		if (reg2_wr) begin
			reg2 <= bus.db;
		end
		if (reg3_wr) begin
			reg3 <= bus.db;
		end
		if (reg4_wr) begin
			reg4 <= bus.db[1:0];
		end
	end

	assign ctrl = reg0;

	// Status read, bit 0 is high outside vblank
	always_comb begin
		db_out = 8'h00;
		if (reg0_rd) begin
			db_out[0] = !vblank;
		end
	end

	// ROM readback, low address bits come straight from the CPU
	always_comb begin
		if (reg0.rom_read) begin
			ca = {reg3[1:0], reg2, bus.ab[9:2]};
			oc = {reg4, reg3[7:2]};
		end else begin
			ca = 18'h00000;
			oc = 8'h00;
		end
	end

endmodule

/* rtl/irq_ctrl.sv */
// ==========================================================
// IRQ, FIRQ and NMI flags with register enables,
// system reset release after a number of frames
// ==========================================================
`include "k051960_config.svh"

module irq_ctrl (
	input  logic                 clk_6M,
	input  logic                 RES_SYNC,
	input  k051960_pkg::raster_t raster,
	input  k051960_pkg::ctrl_t   ctrl,
	output logic                 irq,
	output logic                 firq,
	output logic                 nmi,
	output logic                 rst
);
	import k051960_pkg::*;

	pos_t row;
	logic vblank_q;
	logic vbl_rise;
	logic firq_evt;
	logic nmi_evt;
	logic [2:0] flag_en;
	logic [2:0] flag_evt;
	logic [2:0] flag_q;
	logic [2:0] frame_cnt;
	logic rst_q;

	// Line number already advanced when line_start is high
	assign row = raster.v;

	// Starts high since the frame leaves reset inside vblank
	always_ff @(posedge clk_6M or negedge RES_SYNC) begin
		if (!RES_SYNC) begin
			vblank_q <= 1'b1;
		end else begin
			vblank_q <= raster.vblank;
		end
	end

	assign vbl_rise = raster.vblank && !vblank_q;
	assign firq_evt = raster.line_start && row[0];
	assign nmi_evt = raster.line_start && (row[`K051960_NMI_BITS-1:0] == '0);

	// Bit order irq, firq, nmi from bit 0
	assign flag_en = {ctrl.nmi_en, ctrl.firq_en, ctrl.irq_en};
	assign flag_evt = {nmi_evt, firq_evt, vbl_rise};

	// Flags hold until the CPU drops the enable
	always_ff @(posedge clk_6M or negedge RES_SYNC) begin
		if (!RES_SYNC) begin
			flag_q <= 3'b000;
		end else begin
			for (int i = 0; i < 3; i++) begin
				if (!flag_en[i]) begin
					flag_q[i] <= 1'b0;
				end else if (flag_evt[i]) begin
					flag_q[i] <= 1'b1;
				end
			end
		end
	end

	// Enable masks the output in the write cycle itself
	assign {nmi, firq, irq} = flag_q & flag_en;

	// Count vblank starts, release on the last one
	always_ff @(posedge clk_6M or negedge RES_SYNC) begin
		if (!RES_SYNC) begin
			frame_cnt <= 3'd0;
			rst_q <= 1'b0;
		end else if (vbl_rise && !rst_q) begin
			if (frame_cnt == 3'(`K051960_RST_FRAMES - 1)) begin
				rst_q <= 1'b1;
			end else begin
				frame_cnt <= frame_cnt + 3'd1;
			end
		end
	end

	assign rst = rst_q;

endmodule

/* rtl/k051960.sv */
// ==========================================================
// Sprite generator frame control top level
// ==========================================================
module k051960 (
	input  logic                  clk_6M,
	input  logic                  RES_SYNC,
	input  logic                  hvin,
	input  k051960_pkg::cpu_bus_t bus,
	output logic [7:0]            db_out,
	output logic [17:0]           ca,
	output logic [7:0]            oc,
	output logic                  irq,
	output logic                  firq,
	output logic                  nmi,
	output logic                  rst,
	output logic                  hvot,
	output logic                  p1h,
	output logic                  p2h
);
	import k051960_pkg::*;

	raster_t raster;
	ctrl_t ctrl;

	raster_counter raster0 (
		.clk_6M   (clk_6M),
		.RES_SYNC (RES_SYNC),
		.hvin     (hvin),
		.raster   (raster)
	);

	cpu_regs regs0 (
		.clk_6M   (clk_6M),
		.RES_SYNC (RES_SYNC),
		.bus      (bus),
		.vblank   (raster.vblank),
		.ctrl     (ctrl),
		.db_out   (db_out),
		.ca       (ca),
		.oc       (oc)
	);

	irq_ctrl irq0 (
		.clk_6M   (clk_6M),
		.RES_SYNC (RES_SYNC),
		.raster   (raster),
		.ctrl     (ctrl),
		.irq      (irq),
		.firq     (firq),
		.nmi      (nmi),
		.rst      (rst)
	);

	// Pixel phases for the companion chip
	assign p1h = raster.h[0];
	assign p2h = raster.h[1];

	// Frame sync out
	assign hvot = raster.frame_tick;

endmodule

/* rtl/k051960_config.svh */
// ==========================================================
// Raster limits, CPU register map, register 0 bit positions
// and the reset release frame count
// ==========================================================
`ifndef K051960_CONFIG_SVH
`define K051960_CONFIG_SVH

// Pixel counter range, 384 pixels per line
`define K051960_H_START 9'h020
`define K051960_H_END 9'h19F

// Line counter range, 264 lines per frame
`define K051960_V_START 9'h0F8
`define K051960_V_END 9'h1FF

// Vblank window, start included and end excluded
`define K051960_VBL_START 9'h1F0
`define K051960_VBL_END 9'h110

// NMI on every line with these low row bits all zero
`define K051960_NMI_BITS 5

// Vblank starts counted before rst is released
`define K051960_RST_FRAMES 8

// Register numbers on ab[2:0]
`define K051960_REG0 3'd0
`define K051960_REG2 3'd2
`define K051960_REG3 3'd3
`define K051960_REG4 3'd4

// Register 0 bits
`define K051960_BIT_IRQ_EN 0
`define K051960_BIT_FIRQ_EN 1
`define K051960_BIT_NMI_EN 2
`define K051960_BIT_ROM_READ 5

`endif

/* rtl/k051960_pkg.sv */
// ==========================================================
// Shared types: raster position and events, CPU bus word,
// register 0 control bits
// ==========================================================
package k051960_pkg;

	// Pixel or line number
	typedef logic [8:0] pos_t;

	// Raster state, one word from the counters
	typedef struct packed {
		pos_t h;
		pos_t v;
		// Pulses for one cycle as h wraps to the line start
		logic line_start;
		// Pulses with line_start when v wraps to the first line
		logic frame_tick;
		logic vblank;
	} raster_t;

	// Synchronous CPU bus on clk_6M
	typedef struct packed {
		logic cs;
		logic wr;
		logic rd;
		logic [10:0] ab;
		logic [7:0] db;
	} cpu_bus_t;

	// Register 0 contents used outside the register file
	typedef struct packed {
		logic rom_read;
		logic irq_en;
		logic firq_en;
		logic nmi_en;
	} ctrl_t;

endpackage

/* rtl/raster_counter.sv */
// ==========================================================
// Pixel and line counters, hvin frame reload, vblank window
// ==========================================================
`include "k051960_config.svh"

module raster_counter (
	input  logic                 clk_6M,
	input  logic                 RES_SYNC,
	input  logic                 hvin,
	output k051960_pkg::raster_t raster
);
	import k051960_pkg::*;

	pos_t h_cnt;
	pos_t v_cnt;
	logic [1:0] hvin_sync;
	logic reload;
	logic line_end;
	logic frame_end;
	logic line_start;
	logic frame_tick;
	logic vblank;

	// External frame sync, two flops
	always_ff @(posedge clk_6M or negedge RES_SYNC) begin
		if (!RES_SYNC) begin
			hvin_sync <= 2'b00;
		end else begin
			hvin_sync <= {hvin_sync[0], hvin};
		end
	end

	assign reload = hvin_sync[1];

	assign line_end = (h_cnt == `K051960_H_END);
	assign frame_end = (v_cnt == `K051960_V_END);

	// Pixel counter
	always_ff @(posedge clk_6M or negedge RES_SYNC) begin
		if (!RES_SYNC) begin
			h_cnt <= `K051960_H_START;
		end else if (line_end) begin
			h_cnt <= `K051960_H_START;
		end else begin
			h_cnt <= h_cnt + 9'd1;
		end
	end

	// Line counter, steps once per line
	always_ff @(posedge clk_6M or negedge RES_SYNC) begin
		if (!RES_SYNC) begin
			v_cnt <= `K051960_V_START;
		end else if (line_end) begin
			// hvin held high pins the frame to its first line
			if (reload || frame_end) begin
				v_cnt <= `K051960_V_START;
			end else begin
				v_cnt <= v_cnt + 9'd1;
			end
		end
	end

	// Events line up with the new h and v values
	always_ff @(posedge clk_6M or negedge RES_SYNC) begin
		if (!RES_SYNC) begin
			line_start <= 1'b0;
			frame_tick <= 1'b0;
		end else begin
			line_start <= line_end;
			frame_tick <= line_end && frame_end;
		end
	end

	// Vblank window wraps through the end of the count
	assign vblank = (v_cnt >= `K051960_VBL_START) || (v_cnt < `K051960_VBL_END);

	always_comb begin
		raster.h = h_cnt;
		raster.v = v_cnt;
		raster.line_start = line_start;
		raster.frame_tick = frame_tick;
		raster.vblank = vblank;
	end

endmodule

/* tb/tb_k051960.sv */
// ==========================================================
// Testbench for the k051960 frame control: raster timing,
// register file, interrupt flags and reset release
// ==========================================================
`include "k051960_config.svh"

module tb_k051960;
	timeunit 1ns;
	timeprecision 1ns;

	import k051960_pkg::*;

	localparam int LINE_CYCLES = 384;
	localparam int FRAME_LINES = 264;
	localparam int FRAME_CYCLES = 101376;
	localparam int V_FIRST = 'h0F8;
	localparam int VBL_FIRST = 'h1F0;
	localparam int VBL_END = 'h110;
	// First vblank start after reset, flags follow one cycle later
	localparam int IRQ_OFFSET = (VBL_FIRST - V_FIRST) * LINE_CYCLES + 1;
	localparam int RST_CYCLE = IRQ_OFFSET + (`K051960_RST_FRAMES - 1) * FRAME_CYCLES;
	localparam int HOLD_CYCLES = FRAME_CYCLES + LINE_CYCLES;
	// Nine frames plus margin for register accesses
	localparam int TIMEOUT_CYCLES = 1_000_000;

	localparam int K_WR = 0;
	localparam int K_CA = 1;
	localparam int K_OC = 2;
	localparam int TABLE_SIZE = 16;

	localparam logic [7:0] EN_IRQ = 8'(1 << `K051960_BIT_IRQ_EN);
	localparam logic [7:0] EN_FIRQ = 8'(1 << `K051960_BIT_FIRQ_EN);
	localparam logic [7:0] EN_NMI = 8'(1 << `K051960_BIT_NMI_EN);
	localparam logic [7:0] EN_ROM = 8'(1 << `K051960_BIT_ROM_READ);

	logic clk_6M;
	logic RES_SYNC;
	logic hvin;
	cpu_bus_t bus;
	logic [7:0] db_out;
	logic [17:0] ca;
	logic [7:0] oc;
	logic irq;
	logic firq;
	logic nmi;
	logic rst;
	logic hvot;
	logic p1h;
	logic p2h;

	int cycle = 0;
	int rel_cycle;
	int n_pass;
	int n_fail;
	int n_entries;

	// Test table
	string t_name [TABLE_SIZE];
	int t_kind [TABLE_SIZE];
	logic [10:0] t_ab [TABLE_SIZE];
	logic [7:0] t_data [TABLE_SIZE];
	logic [17:0] t_exp [TABLE_SIZE];

	k051960 dut0 (
		.clk_6M   (clk_6M),
		.RES_SYNC (RES_SYNC),
		.hvin     (hvin),
		.bus      (bus),
		.db_out   (db_out),
		.ca       (ca),
		.oc       (oc),
		.irq      (irq),
		.firq     (firq),
		.nmi      (nmi),
		.rst      (rst),
		.hvot     (hvot),
		.p1h      (p1h),
		.p2h      (p2h)
	);

	initial clk_6M = 1'b0;
	always #4 clk_6M = ~clk_6M;

	always @(posedge clk_6M) begin
		cycle <= cycle + 1;
		if (cycle >= TIMEOUT_CYCLES) begin
			$display("Timeout: no result after %0d clock cycles", cycle);
			$display("=== FAIL ===");
			$finish;
		end
	end

	task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
		if (act === exp) begin
			n_pass++;
			$display("ok    %s", name);
		end else begin
			n_fail++;
			$display("ERROR %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_ca(input string name, input logic [17:0] exp, input logic [17:0] act);
		if (act === exp) begin
			n_pass++;
			$display("ok    %s", name);
		end else begin
			n_fail++;
			$display("ERROR %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act === exp) begin
			n_pass++;
			$display("ok    %s", name);
		end else begin
			n_fail++;
			$display("ERROR %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (act == exp) begin
			n_pass++;
			$display("ok    %s", name);
		end else begin
			n_fail++;
			$display("ERROR %s: expected %0d, actual %0d", name, exp, act);
		end
	endtask

	function automatic logic [10:0] reg_addr(input logic [2:0] n);
		return {8'h00, n};
	endfunction

	// Raster position from posedges since reset release
	function automatic logic vblank_at(input int k);
		int v;
		v = V_FIRST + (k / LINE_CYCLES) % FRAME_LINES;
		return (v >= VBL_FIRST) || (v < VBL_END);
	endfunction

	// One cycle on, outputs read just after the falling edge
	task automatic step();
		@(negedge clk_6M);
		#1;
	endtask

	task automatic reg_write(input logic [10:0] ab, input logic [7:0] data);
		@(negedge clk_6M);
		bus.cs = 1'b1;
		bus.wr = 1'b1;
		bus.ab = ab;
		bus.db = data;
		@(negedge clk_6M);
		bus.cs = 1'b0;
		bus.wr = 1'b0;
		#1;
	endtask

	task automatic read_status(input string name);
		logic [7:0] exp;
		logic [7:0] got;
		@(negedge clk_6M);
		bus.cs = 1'b1;
		bus.rd = 1'b1;
		bus.ab = reg_addr(`K051960_REG0);
		#1;
		got = db_out;
		exp = {7'b0000000, ~vblank_at(cycle - rel_cycle)};
		@(negedge clk_6M);
		bus.cs = 1'b0;
		bus.rd = 1'b0;
		#1;
		check_byte(name, exp, got);
	endtask

	task automatic add_entry(input string name, input int kind, input logic [10:0] ab,
			input logic [7:0] data, input logic [17:0] exp);
		t_name[n_entries] = name;
		t_kind[n_entries] = kind;
		t_ab[n_entries] = ab;
		t_data[n_entries] = data;
		t_exp[n_entries] = exp;
		n_entries++;
	endtask

	task automatic build_table();
		logic [7:0] r2;
		logic [7:0] r3;
		logic [7:0] r4;
		logic [10:0] ab;
		r2 = 8'($urandom);
		r3 = 8'($urandom);
		r4 = 8'($urandom);
		add_entry("write_reg2", K_WR, reg_addr(`K051960_REG2), r2, 18'h0);
		add_entry("write_reg3", K_WR, reg_addr(`K051960_REG3), r3, 18'h0);
		add_entry("write_reg4", K_WR, reg_addr(`K051960_REG4), r4, 18'h0);
		add_entry("rom_read_on", K_WR, reg_addr(`K051960_REG0), EN_ROM, 18'h0);
		for (int j = 0; j < 3; j++) begin
			ab = 11'($urandom);
			// Bank bits above the CPU word address
			add_entry($sformatf("ca_rom_%0d", j), K_CA, ab, 8'h00, {r3[1:0], r2, ab[9:2]});
			add_entry($sformatf("oc_rom_%0d", j), K_OC, ab, 8'h00,
				{10'h000, r4[1:0], r3[7:2]});
		end
		add_entry("rom_read_off", K_WR, reg_addr(`K051960_REG0), 8'h00, 18'h0);
		ab = 11'($urandom);
		add_entry("ca_off", K_CA, ab, 8'h00, 18'h0);
		add_entry("oc_off", K_OC, ab, 8'h00, 18'h0);
	endtask

	task automatic apply_table();
		for (int i = 0; i < n_entries; i++) begin
			if (t_kind[i] == K_WR) begin
				reg_write(t_ab[i], t_data[i]);
			end else begin
				@(negedge clk_6M);
				bus.ab = t_ab[i];
				#1;
				if (t_kind[i] == K_CA) begin
					check_ca(t_name[i], t_exp[i], ca);
				end else begin
					check_byte(t_name[i], t_exp[i][7:0], oc);
				end
			end
		end
	endtask

	initial begin
		int t0;
		int k;
		int toggles;
		int toggles_p2h;
		int firq_cnt;
		int nmi_cnt;
		int hvot_cnt;
		logic last;
		logic last_p2h;
		RES_SYNC = 1'b0;
		hvin = 1'b0;
		bus = '0;
		n_pass = 0;
		n_fail = 0;
		n_entries = 0;
		void'($urandom(32'hf913));
		repeat (10) @(negedge clk_6M);
		RES_SYNC = 1'b1;
		rel_cycle = cycle;
		#1;

		// Quiet outputs out of reset
		check_flag("irq_reset", 1'b0, irq);
		check_flag("firq_reset", 1'b0, firq);
		check_flag("nmi_reset", 1'b0, nmi);
		check_flag("rst_reset", 1'b0, rst);
		check_flag("hvot_reset", 1'b0, hvot);
		check_byte("db_out_reset", 8'h00, db_out);
		last = p1h;
		last_p2h = p2h;
		toggles = 0;
		toggles_p2h = 0;
		repeat (8) begin
			step();
			if (p1h != last) begin
				toggles++;
			end
			if (p2h != last_p2h) begin
				toggles_p2h++;
			end
			last = p1h;
			last_p2h = p2h;
		end
		check_count("p1h_toggle", 8, toggles);
		// p2h runs at half the p1h rate
		check_count("p2h_toggle", 4, toggles_p2h);

		// Frame length, status read inside and outside vblank
		do begin
			step();
		end while (!hvot);
		t0 = cycle;
		read_status("status_vblank");
		while (cycle - t0 < 40 * LINE_CYCLES) begin
			step();
		end
		read_status("status_active");
		do begin
			step();
		end while (!hvot);
		check_count("hvot_period", FRAME_CYCLES, cycle - t0);

		// ROM readback
		build_table();
		apply_table();

		// IRQ once per frame, cleared by its enable
		reg_write(reg_addr(`K051960_REG0), EN_IRQ);
		do begin
			step();
		end while (!irq);
		k = cycle - rel_cycle;
		check_count("irq_phase", 0, (k - IRQ_OFFSET) % FRAME_CYCLES);
		t0 = cycle;
		reg_write(reg_addr(`K051960_REG0), 8'h00);
		check_flag("irq_clear", 1'b0, irq);
		reg_write(reg_addr(`K051960_REG0), EN_IRQ);
		do begin
			step();
		end while (!irq);
		check_count("irq_period", FRAME_CYCLES, cycle - t0);

		// FIRQ and NMI over one frame, each acknowledged by its enable
		reg_write(reg_addr(`K051960_REG0), EN_FIRQ | EN_NMI);
		firq_cnt = 0;
		nmi_cnt = 0;
		t0 = cycle;
		while (cycle - t0 < FRAME_CYCLES) begin
			step();
			if (firq) begin
				firq_cnt++;
				reg_write(reg_addr(`K051960_REG0), EN_NMI);
				reg_write(reg_addr(`K051960_REG0), EN_FIRQ | EN_NMI);
			end
			if (nmi) begin
				nmi_cnt++;
				reg_write(reg_addr(`K051960_REG0), EN_FIRQ);
				reg_write(reg_addr(`K051960_REG0), EN_FIRQ | EN_NMI);
			end
		end
		// Odd lines of 264, and lines 0x100 to 0x1E0 in steps of 32
		check_count("firq_per_frame", 132, firq_cnt);
		check_count("nmi_per_frame", 8, nmi_cnt);

		// Reset release on the eighth vblank start
		do begin
			step();
		end while (!rst);
		check_count("rst_release", RST_CYCLE, cycle - rel_cycle);

		// hvin held high pins the frame, so no hvot
		@(negedge clk_6M);
		hvin = 1'b1;
		hvot_cnt = 0;
		t0 = cycle;
		while (cycle - t0 < HOLD_CYCLES) begin
			step();
			if (hvot) begin
				hvot_cnt++;
			end
		end
		@(negedge clk_6M);
		hvin = 1'b0;
		check_count("hvot_hvin_hold", 0, hvot_cnt);

		$display("Checks: %0d passed, %0d failed", n_pass, n_fail);
		if (n_fail == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule
